/* bench/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam logic [7:0] exc_vec = 8'h30;
    localparam int         wait_limit = 1000;

    typedef struct packed {
        logic [2:0] rd;
        logic [7:0] data;
    } commit_t;

    logic        clk;
    logic        rst_n;
    logic        i_stall;
    logic        d_stall;
    logic [7:0]  imem_addr;
    logic [15:0] imem_rdata;
    logic        dmem_req;
    logic        dmem_we;
    logic [7:0]  dmem_addr;
    logic [7:0]  dmem_wdata;
    logic [7:0]  dmem_rdata;
    logic        commit_valid;
    logic [2:0]  commit_rd;
    logic [7:0]  commit_data;
    logic        exception;

    logic [15:0] rom [256];
    logic [7:0]  ram [256];
    commit_t     exp_q [$];
    int          exp_exc;
    int          exc_count;
    logic        exc_prev;
    logic        seen_commit;
    logic        checking;
    logic [31:0] rng;

    mini_core #(.exc_vector(exc_vec)) dut_i (
        .clk, .rst_n, .imem_addr, .imem_rdata, .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata,
        .dmem_rdata, .i_stall, .d_stall, .commit_valid, .commit_rd, .commit_data, .exception
    );

    // both memories answer in the same cycle
    assign imem_rdata = rom[imem_addr];
    assign dmem_rdata = ram[dmem_addr];

    always @(posedge clk) begin
        if (dmem_req && dmem_we && !d_stall) begin
            ram[dmem_addr] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [15:0] encode(input logic [2:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [2:0] rt,
                                           input logic [3:0] imm);
        return {op, rd, rs, rt, imm};
    endfunction

    function automatic logic [7:0] reg_init(input int idx);
        return 8'(idx * 13);
    endfunction

    function automatic logic [7:0] ram_init(input int addr);
        return 8'(addr * 7 + 3);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic load_memories();
        for (int i = 0; i < 256; i++) begin
            rom[i] = encode(op_beq, 3'(i % 7), 3'd0, 3'd0, 4'hf);  // self loops everywhere else
            ram[i] = ram_init(i);
        end
        rom[0]  = encode(op_addi, 3'd1, 3'd0, 3'd0, 4'd5);
        rom[1]  = encode(op_addi, 3'd2, 3'd0, 3'd0, 4'hd);   // minus 3
        rom[2]  = encode(op_add, 3'd3, 3'd1, 3'd2, 4'd0);
        rom[3]  = encode(op_sub, 3'd4, 3'd1, 3'd2, 4'd0);
        rom[4]  = encode(op_store, 3'd0, 3'd0, 3'd3, 4'd2);
        rom[5]  = encode(op_load, 3'd5, 3'd0, 3'd0, 4'd2);
        rom[6]  = encode(op_add, 3'd6, 3'd5, 3'd1, 4'd0);    // needs the load result at once
        rom[7]  = encode(op_beq, 3'd0, 3'd1, 3'd1, 4'd2);    // taken over 8 and 9
        rom[8]  = encode(op_addi, 3'd7, 3'd0, 3'd0, 4'd1);
        rom[9]  = encode(op_addi, 3'd7, 3'd0, 3'd0, 4'd2);
        rom[10] = encode(op_beq, 3'd0, 3'd1, 3'd2, 4'd3);    // not taken
        rom[11] = encode(op_addi, 3'd7, 3'd6, 3'd0, 4'd4);
        rom[12] = encode(3'd6, 3'd1, 3'd1, 3'd1, 4'd0);
        rom[13] = encode(op_addi, 3'd1, 3'd0, 3'd0, 4'd7);
        rom[14] = encode(op_addi, 3'd2, 3'd0, 3'd0, 4'd7);
        // handler code at the exception vector
        rom[exc_vec]     = encode(op_addi, 3'd1, 3'd1, 3'd0, 4'd1);
        rom[exc_vec + 1] = encode(op_store, 3'd0, 3'd0, 3'd1, 4'd5);
        rom[exc_vec + 2] = encode(op_load, 3'd2, 3'd0, 3'd0, 4'd5);
        rom[exc_vec + 3] = encode(op_sub, 3'd3, 3'd2, 3'd4, 4'd0);
        rom[exc_vec + 4] = encode(op_load, 3'd4, 3'd0, 3'd0, 4'd9);
    endtask

    // instruction-set model that walks the program and queues every register write
    task automatic build_expected();
        logic [15:0] w;
        logic [2:0]  op;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  imm8;
        logic [7:0]  addr;
        logic [7:0]  wdata;
        logic        writes;
        logic [7:0]  pc;
        logic [7:0]  next_pc;
        logic [7:0]  mregs [8];
        logic [7:0]  mram [256];
        logic        halted;
        int          steps;
        commit_t     c;
        exp_q.delete();
        exp_exc = 0;
        for (int i = 0; i < 8; i++) begin
            mregs[i] = reg_init(i);
        end
        for (int i = 0; i < 256; i++) begin
            mram[i] = ram_init(i);
        end
        pc = 8'd0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 200) begin
            w = rom[pc];
            op = w[15:13];
            a = mregs[w[9:7]];
            b = mregs[w[6:4]];
            imm8 = {{4{w[3]}}, w[3:0]};
            addr = a + imm8;
            next_pc = pc + 8'd1;
            writes = 1'b1;
            wdata = 8'd0;
            case (op)
                op_add:   wdata = a + b;
                op_sub:   wdata = a - b;
                op_addi:  wdata = a + imm8;
                op_load:  wdata = mram[addr];
                op_store: begin
                    mram[addr] = b;
                    writes = 1'b0;
                end
                op_beq: begin
                    writes = 1'b0;
                    if (a == b) begin
                        next_pc = pc + 8'd1 + imm8;
                        halted = (next_pc == pc);
                    end
                end
                default: begin
                    writes = 1'b0;
                    exp_exc++;
                    next_pc = exc_vec;  // nothing after the illegal word runs
                end
            endcase
            if (writes) begin
                mregs[w[12:10]] = wdata;
                c.rd = w[12:10];
                c.data = wdata;
                exp_q.push_back(c);
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic run_pass(input logic random_stalls);
        int cycles;
        checking = 1'b0;
        rst_n   <= 1'b0;
        i_stall <= 1'b0;
        d_stall <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        load_memories();
        build_expected();
        // preload the register file through the hierarchy
        for (int i = 0; i < 8; i++) begin
            dut_i.decode_i.regs[i] = reg_init(i);
        end
        assert (commit_valid === 1'b0 && exception === 1'b0)
            else abort_run($sformatf("mismatch at %0t ns: commit_valid or exception set in reset",
                                     $time));
        exc_count = 0;
        exc_prev = 1'b0;
        seen_commit = 1'b0;
        checking = 1'b1;
        @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < wait_limit) begin
            @(posedge clk);
            if (random_stalls) begin
                rng = xorshift(rng);
                i_stall <= (rng[2:0] < 3'd3);
                d_stall <= (rng[10:8] == 3'd0);
            end
            cycles++;
        end
        assert (exp_q.size() == 0)
            else abort_run($sformatf("timed out with %0d commits still missing", exp_q.size()));
        i_stall <= 1'b0;
        d_stall <= 1'b0;
        // quiet window in which any extra commit would show up
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
        end
        assert (exc_count == exp_exc)
            else abort_run($sformatf("mismatch at %0t ns: %0d exception pulses, expected %0d",
                                     $time, exc_count, exp_exc));
    endtask

    always @(negedge clk) begin
        commit_t head;
        if (checking && rst_n) begin
            if (commit_valid) begin
                assert (exp_q.size() > 0)
                    else abort_run($sformatf("unexpected commit of r%0d at %0t ns",
                                             commit_rd, $time));
                head = exp_q.pop_front();
                assert (commit_rd === head.rd && commit_data === head.data)
                    else abort_run($sformatf(
                        "mismatch at %0t ns: r%0d = %02h, expected r%0d = %02h",
                        $time, commit_rd, commit_data, head.rd, head.data));
                seen_commit = 1'b1;
            end
            if (exception) begin
                assert (seen_commit) else abort_run("exception rose before the first commit");
                assert (!exc_prev) else abort_run("exception stayed high for more than one cycle");
                exc_count++;
            end
            exc_prev = exception;
        end
    end

    initial begin
        rst_n = 1'b0;
        i_stall = 1'b0;
        d_stall = 1'b0;
        checking = 1'b0;
        rng = 32'd99280;
        run_pass(1'b0);
        run_pass(1'b1);  // same program under random back-pressure
        $display("Simulation completed successfully");
        $finish;
    end
endmodule

`default_nettype wire

/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int reg_bits = 8;
    localparam int pc_bits = 8;
    localparam int instr_bits = 16;
    localparam int op_bits = 3;
    localparam int reg_idx_bits = 3;
    localparam int imm_bits = 4;
    localparam int num_regs = 2 ** reg_idx_bits;

    // codes 6 and 7 are left free and decode as illegal
    typedef enum logic [op_bits-1:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_addi  = 3'd2,
        op_load  = 3'd3,
        op_store = 3'd4,
        op_beq   = 3'd5
    } op_e;

    typedef struct packed {
        op_e                     op;
        logic [reg_idx_bits-1:0] rd;
        logic [reg_idx_bits-1:0] rs;
        logic [reg_idx_bits-1:0] rt;
        logic [imm_bits-1:0]     imm;
    } instr_t;

    typedef struct packed {
        logic               valid;
        logic [pc_bits-1:0] pc;
        instr_t             instr;
    } if_id_t;

    typedef struct packed {
        logic                    valid;
        logic [pc_bits-1:0]      pc;
        op_e                     op;
        logic [reg_idx_bits-1:0] rd;
        logic [reg_bits-1:0]     a;    // rs value
        logic [reg_bits-1:0]     b;    // rt value
        logic [reg_bits-1:0]     imm;  // already sign-extended
        logic                    we;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        op_e                     op;
        logic [reg_idx_bits-1:0] rd;
        logic [reg_bits-1:0]     result;
        logic [reg_bits-1:0]     store_data;
        logic                    we;
    } ex_mem_t;

    typedef struct packed {
        logic                    valid;
        logic [reg_idx_bits-1:0] rd;
        logic [reg_bits-1:0]     data;
        logic                    we;
    } mem_wb_t;

endpackage

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire core_pkg::if_id_t  if_id,
    input  wire                 id_ex_stall,
    input  wire                 id_ex_flush,
    input  wire core_pkg::ex_mem_t ex_mem,
    input  wire core_pkg::mem_wb_t wb,
    output core_pkg::id_ex_t    id_ex,
    output logic                raw_stall_req
);
    import core_pkg::*;

    logic [reg_bits-1:0] regs [num_regs];
    instr_t              instr;
    logic [reg_bits-1:0] rs_val;
    logic [reg_bits-1:0] rt_val;
    logic                writes_rd;
    logic                uses_rt;
    logic                rs_busy;
    logic                rt_busy;

    function automatic logic pending(input logic valid, input logic we,
                                     input logic [reg_idx_bits-1:0] rd,
                                     input logic [reg_idx_bits-1:0] src);
        return valid & we & (rd == src);
    endfunction

    assign instr = if_id.instr;

    always_ff @(posedge clk) begin
        if (wb.valid && wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // a write landing this cycle is seen by the read
    assign rs_val = (wb.valid && wb.we && wb.rd == instr.rs) ? wb.data : regs[instr.rs];
    assign rt_val = (wb.valid && wb.we && wb.rd == instr.rt) ? wb.data : regs[instr.rt];

    assign writes_rd = instr.op inside {op_add, op_sub, op_addi, op_load};
    assign uses_rt   = instr.op inside {op_add, op_sub, op_store, op_beq};

    assign rs_busy = pending(id_ex.valid, id_ex.we, id_ex.rd, instr.rs)
                   | pending(ex_mem.valid, ex_mem.we, ex_mem.rd, instr.rs)
                   | pending(wb.valid, wb.we, wb.rd, instr.rs);
    assign rt_busy = pending(id_ex.valid, id_ex.we, id_ex.rd, instr.rt)
                   | pending(ex_mem.valid, ex_mem.we, ex_mem.rd, instr.rt)
                   | pending(wb.valid, wb.we, wb.rd, instr.rt);

    // without forwarding the reader waits until its writer has retired
    assign raw_stall_req = if_id.valid & (rs_busy | (uses_rt & rt_busy));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (id_ex_flush) begin
            id_ex.valid <= 1'b0;
        end else if (!id_ex_stall) begin
            id_ex.valid <= if_id.valid;
            id_ex.pc    <= if_id.pc;
            id_ex.op    <= instr.op;
            id_ex.rd    <= instr.rd;
            id_ex.a     <= rs_val;
            id_ex.b     <= rt_val;
            id_ex.imm   <= {{(reg_bits - imm_bits){instr.imm[imm_bits-1]}}, instr.imm};
            id_ex.we    <= writes_rd;
        end
    end
endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire core_pkg::id_ex_t      id_ex,
    input  wire                        ex_mem_stall,
    input  wire                        ex_mem_flush,
    output core_pkg::ex_mem_t          ex_mem,
    output logic                       branch_flush_req,
    output logic [core_pkg::pc_bits-1:0] branch_target,
    output logic                       exception_flush
);
    import core_pkg::*;

    logic                illegal;
    logic                taken;
    logic [reg_bits-1:0] result;

    assign illegal = !(id_ex.op inside {op_add, op_sub, op_addi, op_load, op_store, op_beq});
    assign taken   = (id_ex.op == op_beq) && (id_ex.a == id_ex.b);

    assign exception_flush  = id_ex.valid & illegal;
    assign branch_flush_req = id_ex.valid & taken;

    // offset counts from the instruction after the beq
    assign branch_target = id_ex.pc + pc_bits'(1) + id_ex.imm;

    always_comb begin
        case (id_ex.op)
            op_add: begin
                result = id_ex.a + id_ex.b;
            end
            op_sub: begin
                result = id_ex.a - id_ex.b;
            end
            op_addi, op_load, op_store: begin
                result = id_ex.a + id_ex.imm;  // memory ops use it as the address
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (ex_mem_flush) begin
            ex_mem.valid <= 1'b0;
        end else if (!ex_mem_stall) begin
            ex_mem.valid      <= id_ex.valid & ~illegal;
            ex_mem.op         <= id_ex.op;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= result;
            ex_mem.store_data <= id_ex.b;
            ex_mem.we         <= id_ex.we;
        end
    end
endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter logic [core_pkg::pc_bits-1:0] exc_vector = '0
) (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               pc_stall,
    input  wire                               if_id_stall,
    input  wire                               if_id_flush,
    input  wire                               branch_flush_req,
    input  wire  [core_pkg::pc_bits-1:0]      branch_target,
    input  wire                               exception_flush,
    input  wire  [core_pkg::instr_bits-1:0]   imem_rdata,
    output logic [core_pkg::pc_bits-1:0]      imem_addr,
    output core_pkg::if_id_t                  if_id
);
    import core_pkg::*;

    logic [pc_bits-1:0] pc;
    logic [pc_bits-1:0] pc_next;
    logic               fetch_bubble;

    assign imem_addr = pc;

    // the pc froze while if_id keeps moving, so this cycle's word is not usable
    assign fetch_bubble = pc_stall & ~if_id_stall;

    always_comb begin
        if (pc_stall) begin
            pc_next = pc;
        end else if (exception_flush) begin
            pc_next = exc_vector;  // wins over a branch
        end else if (branch_flush_req) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + pc_bits'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (if_id_flush) begin
            if_id.valid <= 1'b0;
        end else if (!if_id_stall) begin
            if_id.valid <= ~fetch_bubble;
            if_id.pc    <= pc;
            if_id.instr <= instr_t'(imem_rdata);
        end
    end
endmodule

`default_nettype wire

/* design/hazard_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl (
    input  wire  i_stall,
    input  wire  d_stall,
    input  wire  raw_stall_req,
    input  wire  branch_flush_req,
    input  wire  exception_flush,

    output logic pc_stall,
    output logic if_id_stall,
    output logic if_id_flush,
    output logic id_ex_stall,
    output logic id_ex_flush,
    output logic ex_mem_stall,
    output logic ex_mem_flush,
    output logic mem_wb_stall
);
    logic flush_any;

    // an exception and a taken branch both redirect fetch
    assign flush_any = branch_flush_req | exception_flush;

    // a redirect must still load the pc even when fetch or decode is waiting
    assign pc_stall =
            d_stall | ((i_stall | raw_stall_req) & ~flush_any);

    assign if_id_stall =
            d_stall | (raw_stall_req & ~flush_any);

    // flushes wait while the data side holds the whole pipe
    assign if_id_flush =
            ~d_stall & flush_any;

    assign id_ex_stall =
            d_stall;

    assign id_ex_flush =
            ~d_stall & (flush_any | raw_stall_req);  // raw stall drops a bubble here

    assign ex_mem_stall =
            d_stall;

    assign ex_mem_flush =
            ~d_stall & exception_flush;

    assign mem_wb_stall =
            d_stall;
endmodule

`default_nettype wire

/* design/mem_wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire core_pkg::ex_mem_t           ex_mem,
    input  wire                              mem_wb_stall,
    input  wire                              d_stall,
    input  wire  [core_pkg::reg_bits-1:0]    dmem_rdata,
    input  wire                              exception_flush,
    output logic                             dmem_req,
    output logic                             dmem_we,
    output logic [core_pkg::reg_bits-1:0]    dmem_addr,
    output logic [core_pkg::reg_bits-1:0]    dmem_wdata,
    output core_pkg::mem_wb_t                wb,
    output logic                             commit_valid,
    output logic [core_pkg::reg_idx_bits-1:0] commit_rd,
    output logic [core_pkg::reg_bits-1:0]    commit_data,
    output logic                             exception
);
    import core_pkg::*;

    logic is_load;
    logic is_store;

    assign is_load  = ex_mem.valid & (ex_mem.op == op_load);
    assign is_store = ex_mem.valid & (ex_mem.op == op_store);

    assign dmem_req   = is_load | is_store;
    assign dmem_we    = is_store;
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!mem_wb_stall) begin
            wb.valid <= ex_mem.valid;
            wb.rd    <= ex_mem.rd;
            wb.data  <= is_load ? dmem_rdata : ex_mem.result;
            wb.we    <= ex_mem.we;
        end
    end

    // commit_valid pulses once per retiring write even if wb is then held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            exception    <= 1'b0;
        end else begin
            commit_valid <= ~mem_wb_stall & ex_mem.valid & ex_mem.we;
            exception    <= exception_flush & ~d_stall;  // the flush only acts once d_stall drops
        end
    end

    assign commit_rd   = wb.rd;
    assign commit_data = wb.data;
endmodule

`default_nettype wire

/* design/mini_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mini_core #(
    parameter logic [core_pkg::pc_bits-1:0] exc_vector = 8'h40
) (
    input  wire                               clk,
    input  wire                               rst_n,
    output logic [core_pkg::pc_bits-1:0]      imem_addr,
    input  wire  [core_pkg::instr_bits-1:0]   imem_rdata,
    output logic                              dmem_req,
    output logic                              dmem_we,
    output logic [core_pkg::reg_bits-1:0]     dmem_addr,
    output logic [core_pkg::reg_bits-1:0]     dmem_wdata,
    input  wire  [core_pkg::reg_bits-1:0]     dmem_rdata,
    input  wire                               i_stall,
    input  wire                               d_stall,
    output logic                              commit_valid,
    output logic [core_pkg::reg_idx_bits-1:0] commit_rd,
    output logic [core_pkg::reg_bits-1:0]     commit_data,
    output logic                              exception
);
    import core_pkg::*;

    if_id_t             if_id;
    id_ex_t             id_ex;
    ex_mem_t            ex_mem;
    mem_wb_t            wb;
    logic [pc_bits-1:0] branch_target;
    logic raw_stall_req, branch_flush_req, exception_flush;
    logic pc_stall, if_id_stall, if_id_flush, id_ex_stall, id_ex_flush;
    logic ex_mem_stall, ex_mem_flush, mem_wb_stall;

    hazard_ctrl ctrl_i (
        .i_stall, .d_stall, .raw_stall_req, .branch_flush_req, .exception_flush,
        .pc_stall, .if_id_stall, .if_id_flush, .id_ex_stall, .id_ex_flush,
        .ex_mem_stall, .ex_mem_flush, .mem_wb_stall
    );

    fetch_stage #(.exc_vector(exc_vector)) fetch_i (
        .clk, .rst_n, .pc_stall, .if_id_stall, .if_id_flush, .branch_flush_req,
        .branch_target, .exception_flush, .imem_rdata, .imem_addr, .if_id
    );

    decode_stage decode_i (
        .clk, .rst_n, .if_id, .id_ex_stall, .id_ex_flush, .ex_mem, .wb,
        .id_ex, .raw_stall_req
    );

    execute_stage execute_i (
        .clk, .rst_n, .id_ex, .ex_mem_stall, .ex_mem_flush, .ex_mem,
        .branch_flush_req, .branch_target, .exception_flush
    );

    mem_wb_stage mem_wb_i (
        .clk, .rst_n, .ex_mem, .mem_wb_stall, .d_stall, .dmem_rdata, .exception_flush,
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .wb,
        .commit_valid, .commit_rd, .commit_data, .exception
    );
endmodule

`default_nettype wire

/* tb.f */
design/core_pkg.sv
design/hazard_ctrl.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/mini_core.sv
bench/core_tb.sv
